/* mem_share.f */
source/mem_access_pkg.sv
source/port_arb_pkg.sv
source/rr_arb_tree.sv
source/sram_bank.sv
source/rsp_router.sv
source/mem_share_top.sv
sim/tb_clk_gen.sv
sim/tb_mem_share.sv

/* Bender.yml */
package:
  name: mem_share

sources:
  # packages first, the RTL refers to them by scoped names
  - source/mem_access_pkg.sv
  - source/port_arb_pkg.sv
  # design
  - source/rr_arb_tree.sv
  - source/sram_bank.sv
  - source/rsp_router.sv
  - source/mem_share_top.sv
  # testbench
  - target: simulation
    files:
      - sim/tb_clk_gen.sv
      - sim/tb_mem_share.sv

/* sim/tb_mem_share.sv */
////////////////////
// shared memory bank testbench
////////////////////

`timescale 1ns/1ps

module tb_mem_share;

  localparam int unsigned NumPorts = 5;
  localparam int unsigned Levels   = $clog2(NumPorts);
  // cycles a requester waits before it is written off
  localparam int unsigned WaitLimit  = 100;
  localparam int unsigned StimCycles = 10 + 256 + 8 + 40 + 80 + 60 + 400 + 10;
  localparam int unsigned MaxCycles  = 4 * StimCycles + 100;

  logic clk;
  logic rst_n;
  logic flush;
  logic stall;
  logic [NumPorts-1:0] req;
  mem_access_pkg::mem_req_t [NumPorts-1:0] req_data;
  logic [NumPorts-1:0] gnt;
  mem_access_pkg::mem_rsp_t [NumPorts-1:0] rsp;

  // model state
  mem_access_pkg::mem_data_t mem_m [256];
  port_arb_pkg::port_idx_t   rr_m;
  logic                      lock_m;
  logic [NumPorts-1:0]       frozen_m;
  mem_access_pkg::mem_rsp_t  exp_now [NumPorts];
  // grants seen in the cycle that just ended
  logic [NumPorts-1:0]       last_gnt;
  int fair_wait [NumPorts];
  bit fair_check = 1'b0;
  int err_cnt = 0;
  int ungranted_cnt = 0;
  int cycles = 0;
  integer seed = 32'h894a_0a99;

  tb_clk_gen i_clk_gen (
    .clk_o  ( clk   ),
    .rst_no ( rst_n )
  );

  mem_share_top #(
    .NumPorts ( NumPorts ),
    .LockIn   ( 1'b1     )
  ) dut_i (
    .clk_i      ( clk      ),
    .rst_ni     ( rst_n    ),
    .flush_i    ( flush    ),
    .stall_i    ( stall    ),
    .req_i      ( req      ),
    .req_data_i ( req_data ),
    .gnt_o      ( gnt      ),
    .rsp_o      ( rsp      )
  );

  ////////////////////
  // reference model
  ////////////////////
  // walk down from the root
  // level 0 follows the top counter bit
  function automatic int pick_winner(input logic [NumPorts-1:0] req_vec,
                                     input port_arb_pkg::port_idx_t rr);
    logic [port_arb_pkg::MaxPorts-1:0] padded;
    int lo;
    int span;
    logic left_any;
    logic right_any;
    padded = '0;
    padded[NumPorts-1:0] = req_vec;
    lo = 0;
    span = 2 ** Levels;
    for (int lvl = 0; lvl < Levels; lvl++) begin
      span = span / 2;
      left_any  = |((padded >> lo) & ((1 << span) - 1));
      right_any = |((padded >> (lo + span)) & ((1 << span) - 1));
      // right side if left is idle or the counter bit favours it
      if (!left_any || (right_any && rr[Levels-1-lvl])) begin
        lo = lo + span;
      end
    end
    if (padded[lo]) begin
      return lo;
    end
    return -1;
  endfunction

  task automatic check_gnt(input logic [NumPorts-1:0] got, input logic [NumPorts-1:0] exp);
    if (got !== exp) begin
      $display("ERROR %0t: grant vector %b, expected %b", $time, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_rsp(input int p, input mem_access_pkg::mem_rsp_t got,
                           input mem_access_pkg::mem_rsp_t exp);
    if (got.valid !== exp.valid || (exp.valid && got.rdata !== exp.rdata)) begin
      $display("ERROR %0t: port %0d response valid %b data %h, expected valid %b data %h",
               $time, p, got.valid, got.rdata, exp.valid, exp.rdata);
      err_cnt++;
    end
  endtask

  // inputs and grants are settled at the falling edge
  always @(negedge clk) begin : compare_proc
    logic [NumPorts-1:0] eff_req;
    logic [NumPorts-1:0] exp_gnt;
    mem_access_pkg::mem_req_t win_req;
    mem_access_pkg::mem_rsp_t exp_next [NumPorts];
    int win;
    if (!rst_n) begin
      rr_m     = '0;
      lock_m   = 1'b0;
      frozen_m = '0;
      last_gnt = '0;
      for (int p = 0; p < NumPorts; p++) begin
        exp_now[p]   = '0;
        fair_wait[p] = 0;
      end
    end else begin
      // a locked arbiter decides on the captured request vector
      eff_req = lock_m ? frozen_m : req;
      win     = pick_winner(eff_req, rr_m);
      exp_gnt = '0;
      if (win >= 0 && !stall) begin
        exp_gnt[win] = 1'b1;
      end
      check_gnt(gnt, exp_gnt);
      for (int p = 0; p < NumPorts; p++) begin
        check_rsp(p, rsp[p], exp_now[p]);
        exp_next[p] = '0;
      end
      last_gnt = gnt;
      if (exp_gnt != '0) begin
        win_req = req_data[win];
        if (win_req.we) begin
          for (int b = 0; b < mem_access_pkg::StrbWidth; b++) begin
            if (win_req.strb[b]) begin
              mem_m[win_req.addr][8*b +: 8] = win_req.wdata[8*b +: 8];
            end
          end
        end else begin
          exp_next[win].valid = 1'b1;
          exp_next[win].rdata = mem_m[win_req.addr];
        end
      end
      // every waiting port is served within NumPorts grants of the DUT
      for (int p = 0; p < NumPorts; p++) begin
        if (!req[p] || gnt[p] || !fair_check) begin
          fair_wait[p] = 0;
        end else if (gnt != '0) begin
          fair_wait[p]++;
          if (fair_wait[p] >= NumPorts) begin
            $display("ERROR %0t: port %0d passed over %0d times", $time, p, fair_wait[p]);
            err_cnt++;
          end
        end
      end
      if (flush) begin
        rr_m     = '0;
        lock_m   = 1'b0;
        frozen_m = '0;
      end else begin
        if (exp_gnt != '0) begin
          rr_m = (rr_m == port_arb_pkg::port_idx_t'(NumPorts - 1)) ? '0 : rr_m + 1'b1;
        end
        lock_m   = (eff_req != '0) && stall;
        frozen_m = eff_req;
      end
      for (int p = 0; p < NumPorts; p++) begin
        exp_now[p] = exp_next[p];
      end
    end
  end

  ////////////////////
  // stimulus helpers
  ////////////////////
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  function automatic int rand_range(input int n);
    return ($random(seed) & 32'h7fff_ffff) % n;
  endfunction

  function automatic mem_access_pkg::mem_req_t make_req(input logic we, input int addr,
                                                        input logic [3:0] strb,
                                                        input logic [31:0] wdata);
    mem_access_pkg::mem_req_t r;
    r.we    = we;
    r.addr  = mem_access_pkg::mem_addr_t'(addr);
    r.strb  = strb;
    r.wdata = wdata;
    return r;
  endfunction

  // pattern built from every address bit
  function automatic logic [31:0] fill_word(input int a);
    logic [7:0] b;
    b = 8'(a);
    return {b, ~b, b ^ 8'h3c, 8'(b * 7)};
  endfunction

  // one access on one port held until granted
  task automatic single_access(input int p, input mem_access_pkg::mem_req_t r);
    int guard;
    guard       = 0;
    req_data[p] = r;
    req[p]      = 1'b1;
    next_cycle();
    while (!last_gnt[p] && guard < WaitLimit) begin
      next_cycle();
      guard++;
    end
    if (!last_gnt[p]) begin
      $display("port %0d: single access was never granted", p);
      ungranted_cnt++;
    end
    req[p] = 1'b0;
  endtask

  // let the pending requests finish without new ones
  task automatic drain_requests();
    int guard;
    guard = 0;
    stall = 1'b0;
    flush = 1'b0;
    while (req != '0 && guard < WaitLimit) begin
      next_cycle();
      req = req & ~last_gnt;
      guard++;
    end
    for (int p = 0; p < NumPorts; p++) begin
      if (req[p]) begin
        $display("port %0d: request still pending after the drain", p);
        ungranted_cnt++;
      end
    end
    req = '0;
  endtask

  // random traffic with percentages for request, write, stall start and flush
  task automatic run_traffic(input int n, input int req_pct, input int we_pct,
                             input int stall_pct, input int flush_pct);
    int stall_left;
    int waits [NumPorts];
    stall_left = 0;
    for (int p = 0; p < NumPorts; p++) begin
      waits[p] = 0;
    end
    repeat (n) begin
      next_cycle();
      for (int p = 0; p < NumPorts; p++) begin
        if (req[p] && last_gnt[p]) begin
          req[p] = 1'b0;
        end
        if (req[p]) begin
          waits[p]++;
          if (waits[p] > WaitLimit) begin
            $display("port %0d: request was never granted", p);
            ungranted_cnt++;
            req[p] = 1'b0;
          end
        end else if (rand_range(100) < req_pct) begin
          req_data[p] = make_req(rand_range(100) < we_pct, rand_range(256),
                                 4'(rand_range(15) + 1), $random(seed));
          req[p]      = 1'b1;
          waits[p]    = 0;
        end
      end
      // stall comes in spans of one to six cycles
      if (stall_left > 0) begin
        stall_left--;
      end else if (rand_range(100) < stall_pct) begin
        stall_left = 1 + rand_range(6);
      end
      stall = (stall_left > 0);
      flush = (rand_range(100) < flush_pct);
    end
    drain_requests();
  endtask

  ////////////////////
  // test sequence
  ////////////////////
  initial begin : main_proc
    req      = '0;
    req_data = '0;
    stall    = 1'b0;
    flush    = 1'b0;
    @(posedge rst_n);
    // nothing may be granted on an idle bus
    repeat (10) next_cycle();
    // fill every word with the writes spread over the ports
    for (int a = 0; a < 256; a++) begin
      single_access(a % NumPorts, make_req(1'b1, a, 4'hf, fill_word(a)));
    end
    // byte merge on port 2 and read back
    single_access(2, make_req(1'b1, 8'h5a, 4'hf, 32'h1122_3344));
    single_access(2, make_req(1'b1, 8'h5a, 4'b0101, 32'haabb_ccdd));
    single_access(2, make_req(1'b0, 8'h5a, 4'h0, 32'h0));
    repeat (3) next_cycle();
    // rotation and fairness with all ports busy
    fair_check = 1'b1;
    run_traffic(40, 100, 30, 0, 0);
    fair_check = 1'b0;
    // stall spans with lock-in
    run_traffic(80, 60, 40, 25, 0);
    // flush pulses during traffic
    run_traffic(60, 70, 40, 0, 8);
    // long mixed run
    run_traffic(400, 50, 50, 5, 0);
    repeat (5) next_cycle();
    $display("errors: %0d mismatches, %0d requests never granted", err_cnt, ungranted_cnt);
    if (err_cnt == 0 && ungranted_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // hard limit on run length
  initial begin : watchdog_proc
    while (cycles < MaxCycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", MaxCycles);
    $display("sim failed");
    $finish;
  end

endmodule

/* sim/tb_clk_gen.sv */
////////////////////
// testbench clock and reset
////////////////////

`timescale 1ns/1ps

module tb_clk_gen #(
  // half of the 20 ns period
  parameter int unsigned HalfPeriod  = 10,
  parameter int unsigned ResetCycles = 3
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriod) clk_o = ~clk_o;
  end

  // release reset just after an edge, away from the sampling point
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #2;
    rst_no = 1'b1;
  end

endmodule

/* source/mem_share_top.sv */
////////////////////
// shared memory bank, top level
////////////////////

`timescale 1ns/1ps

module mem_share_top #(
  // number of request ports, 2 to MaxPorts
  parameter int unsigned NumPorts = 4,
  // keep the decision fixed while stalled
  parameter bit          LockIn   = 1'b1
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    flush_i,
  // higher-priority user outside owns the bank
  input  logic                                    stall_i,
  // request ports
  input  logic [NumPorts-1:0]                     req_i,
  input  mem_access_pkg::mem_req_t [NumPorts-1:0] req_data_i,
  output logic [NumPorts-1:0]                     gnt_o,
  output mem_access_pkg::mem_rsp_t [NumPorts-1:0] rsp_o
);

  // arbiter result
  logic                      arb_req;
  logic                      arb_gnt;
  mem_access_pkg::mem_req_t  arb_data;
  port_arb_pkg::port_idx_t   arb_idx;
  // bank strobes and read data
  logic                      bank_req;
  logic                      bank_rd;
  mem_access_pkg::mem_data_t bank_rdata;

  // the bank accepts whenever it is not stalled
  assign arb_gnt  = ~stall_i;
  assign bank_req = arb_req & arb_gnt;
  assign bank_rd  = bank_req & ~arb_data.we;

  rr_arb_tree #(
    .NumPorts ( NumPorts ),
    .LockIn   ( LockIn   )
  ) i_arb (
    .clk_i   ( clk_i      ),
    .rst_ni  ( rst_ni     ),
    .flush_i ( flush_i    ),
    .req_i   ( req_i      ),
    .gnt_o   ( gnt_o      ),
    .data_i  ( req_data_i ),
    .gnt_i   ( arb_gnt    ),
    .req_o   ( arb_req    ),
    .data_o  ( arb_data   ),
    .idx_o   ( arb_idx    )
  );

  sram_bank i_bank (
    .clk_i   ( clk_i          ),
    .rst_ni  ( rst_ni         ),
    .req_i   ( bank_req       ),
    .we_i    ( arb_data.we    ),
    .addr_i  ( arb_data.addr  ),
    .strb_i  ( arb_data.strb  ),
    .wdata_i ( arb_data.wdata ),
    .rdata_o ( bank_rdata     )
  );

  rsp_router #(
    .NumPorts ( NumPorts )
  ) i_router (
    .clk_i   ( clk_i      ),
    .rst_ni  ( rst_ni     ),
    .rd_i    ( bank_rd    ),
    .idx_i   ( arb_idx    ),
    .rdata_i ( bank_rdata ),
    .rsp_o   ( rsp_o      )
  );

endmodule

/* source/rsp_router.sv */
////////////////////
// read response routing
////////////////////

`timescale 1ns/1ps

module rsp_router #(
  parameter int unsigned NumPorts = 4
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  // read accepted by the bank this cycle
  input  logic                                    rd_i,
  // port that won the read
  input  port_arb_pkg::port_idx_t                 idx_i,
  // bank read data, valid the cycle after rd_i
  input  mem_access_pkg::mem_data_t               rdata_i,
  output mem_access_pkg::mem_rsp_t [NumPorts-1:0] rsp_o
);

  // outstanding read and its owner
  logic                    rd_q;
  port_arb_pkg::port_idx_t idx_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_q <= 1'b0;
    end else begin
      rd_q <= rd_i;
    end
  end

  // owner index only matters while rd_q is set
  always_ff @(posedge clk_i) begin
    if (rd_i) begin
      idx_q <= idx_i;
    end
  end

  // steer data to the owner, every other port stays idle
  for (genvar p = 0; p < NumPorts; p++) begin : gen_rsp
    logic hit;
    assign hit            = rd_q & (idx_q == port_arb_pkg::port_idx_t'(p));
    assign rsp_o[p].valid = hit;
    assign rsp_o[p].rdata = hit ? rdata_i : '0;
  end

endmodule

/* source/sram_bank.sv */
////////////////////
// single-port memory bank
////////////////////

`timescale 1ns/1ps

module sram_bank (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // access strobe and request fields
  input  logic                       req_i,
  input  logic                       we_i,
  input  mem_access_pkg::mem_addr_t  addr_i,
  input  mem_access_pkg::mem_strb_t  strb_i,
  input  mem_access_pkg::mem_data_t  wdata_i,
  // read data, one cycle after the strobe
  output mem_access_pkg::mem_data_t  rdata_o
);

  localparam int unsigned NumWords = 2**mem_access_pkg::AddrWidth;

  // storage array
  mem_access_pkg::mem_data_t mem_q [NumWords];

  // byte-enable write, untouched lanes keep their contents
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int unsigned b = 0; b < mem_access_pkg::StrbWidth; b++) begin
        if (strb_i[b]) begin
          mem_q[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // registered read port
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (req_i && !we_i) begin
      rdata_o <= mem_q[addr_i];
    end
  end

endmodule

/* source/rr_arb_tree.sv */
////////////////////
// round-robin arbitration tree
////////////////////

`timescale 1ns/1ps

module rr_arb_tree #(
  parameter int unsigned NumPorts = 4,
  parameter bit          LockIn   = 1'b1
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  // clears counter and lock state
  input  logic                                     flush_i,
  // request side
  input  logic [NumPorts-1:0]                      req_i,
  output logic [NumPorts-1:0]                      gnt_o,
  input  mem_access_pkg::mem_req_t [NumPorts-1:0]  data_i,
  // arbitrated side
  input  logic                                     gnt_i,
  output logic                                     req_o,
  output mem_access_pkg::mem_req_t                 data_o,
  output port_arb_pkg::port_idx_t                  idx_o
);

  if (NumPorts == 1) begin : gen_single
    // nothing to arbitrate
    assign req_o    = req_i[0];
    assign gnt_o[0] = gnt_i;
    assign data_o   = data_i[0];
    assign idx_o    = '0;
  end else begin : gen_tree
    localparam int unsigned NumLevels = $clog2(NumPorts);
    localparam int unsigned NumNodes  = 2**NumLevels - 1;

    // node storage, node 0 is the root
    logic [NumNodes-1:0][NumLevels-1:0]         index_nodes;
    mem_access_pkg::mem_req_t [NumNodes-1:0]    data_nodes;
    logic [NumNodes-1:0]                        req_nodes;
    logic [NumNodes-1:0]                        gnt_nodes;

    // rotating priority counter
    port_arb_pkg::port_idx_t rr_d, rr_q;
    // request vector seen by the tree, frozen while locked
    logic [NumPorts-1:0]     req_d;

    // root of the tree is the arbitration result
    assign req_o        = req_nodes[0];
    assign data_o       = data_nodes[0];
    assign idx_o        = port_arb_pkg::port_idx_t'(index_nodes[0]);
    assign gnt_nodes[0] = gnt_i;

    ////////////////////
    // lock-in
    ////////////////////
    if (LockIn) begin : gen_lock
      logic                lock_q;
      logic [NumPorts-1:0] req_q;

      // while locked the tree sees the captured requests
      assign req_d = lock_q ? req_q : req_i;

      always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
          lock_q <= 1'b0;
          req_q  <= '0;
        end else if (flush_i) begin
          lock_q <= 1'b0;
          req_q  <= '0;
        end else begin
          // pending output request without grant keeps the decision
          lock_q <= req_o & ~gnt_i;
          req_q  <= req_d;
        end
      end
    end else begin : gen_no_lock
      assign req_d = req_i;
    end

    ////////////////////
    // priority counter
    ////////////////////
    // advance on every accepted grant, wrap at the last port
    always_comb begin
      rr_d = rr_q;
      if (req_o && gnt_i) begin
        if (rr_q == port_arb_pkg::port_idx_t'(NumPorts - 1)) begin
          rr_d = '0;
        end else begin
          rr_d = rr_q + 1'b1;
        end
      end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rr_q <= '0;
      end else if (flush_i) begin
        rr_q <= '0;
      end else begin
        rr_q <= rr_d;
      end
    end

    ////////////////////
    // tree levels
    ////////////////////
    for (genvar level = 0; level < NumLevels; level++) begin : gen_levels
      for (genvar n = 0; n < 2**level; n++) begin : gen_nodes
        // this node and its left child
        localparam int unsigned Node  = 2**level - 1 + n;
        localparam int unsigned Child = 2**(level + 1) - 1 + 2 * n;
        // first port below a leaf node
        localparam int unsigned Port  = 2 * n;

        if (level == NumLevels - 1) begin : gen_leaf
          if (Port + 1 < NumPorts) begin : gen_pair
            logic sel;
            // right wins if left is idle or the counter bit favours it
            assign sel = ~req_d[Port] | (req_d[Port+1] & rr_q[NumLevels-1-level]);
            assign req_nodes[Node]   = req_d[Port] | req_d[Port+1];
            assign index_nodes[Node] = NumLevels'(Port) | NumLevels'(sel);
            assign data_nodes[Node]  = sel ? data_i[Port+1] : data_i[Port];
            assign gnt_o[Port]       = gnt_nodes[Node] & req_d[Port] & ~sel;
            assign gnt_o[Port+1]     = gnt_nodes[Node] & req_d[Port+1] & sel;
          end else if (Port + 1 == NumPorts) begin : gen_odd
            // unbalanced leaf, single requester
            assign req_nodes[Node]   = req_d[Port];
            assign index_nodes[Node] = NumLevels'(Port);
            assign data_nodes[Node]  = data_i[Port];
            assign gnt_o[Port]       = gnt_nodes[Node] & req_d[Port];
          end else begin : gen_empty
            // beyond the last port, never requests
            assign req_nodes[Node]   = 1'b0;
            assign index_nodes[Node] = '0;
            assign data_nodes[Node]  = '0;
          end
        end else begin : gen_inner
          logic sel;
          assign sel = ~req_nodes[Child] | (req_nodes[Child+1] & rr_q[NumLevels-1-level]);
          assign req_nodes[Node]   = req_nodes[Child] | req_nodes[Child+1];
          assign index_nodes[Node] = sel ? index_nodes[Child+1] : index_nodes[Child];
          assign data_nodes[Node]  = sel ? data_nodes[Child+1] : data_nodes[Child];
          // grant walks down towards the selected child
          assign gnt_nodes[Child]   = gnt_nodes[Node] & ~sel;
          assign gnt_nodes[Child+1] = gnt_nodes[Node] & sel;
        end
      end
    end
  end

endmodule

/* source/port_arb_pkg.sv */
////////////////////
// request port indexing
////////////////////

package port_arb_pkg;

  // upper limit on the number of request ports
  localparam int unsigned MaxPorts = 8;

  // enough bits to name any port up to MaxPorts
  localparam int unsigned PortIdxWidth = $clog2(MaxPorts);

  // port index, used for the arbiter result and the
  // stored index of an outstanding read
  typedef logic [PortIdxWidth-1:0] port_idx_t;

endpackage

/* source/mem_access_pkg.sv */
////////////////////
// memory request and response types
////////////////////

package mem_access_pkg;

  // word address width, the bank holds 2**AddrWidth words
  localparam int unsigned AddrWidth = 8;
  // data word width
  localparam int unsigned DataWidth = 32;
  // one byte enable per byte lane
  localparam int unsigned StrbWidth = DataWidth / 8;

  typedef logic [AddrWidth-1:0] mem_addr_t;
  typedef logic [DataWidth-1:0] mem_data_t;
  typedef logic [StrbWidth-1:0] mem_strb_t;

  //////////////////////
  // request, 45 bits
  //////////////////////
  // carried as the data word through the arbitration tree
  typedef struct packed {
    logic      we;
    mem_addr_t addr;
    mem_strb_t strb;
    mem_data_t wdata;
  } mem_req_t;

  //////////////////////
  // read response, 33 bits
  //////////////////////
  // valid is high for exactly one cycle per returned read
  typedef struct packed {
    logic      valid;
    mem_data_t rdata;
  } mem_rsp_t;

endpackage
